// ==== zx_mem.f ====
hw/zx_pkg.sv
hw/page_regs.sv
hw/io_ports.sv
hw/mem_arbiter.sv
hw/bank_ram.sv
hw/zx_mem_top.sv
dv/zx_mem_chk.sv
dv/zx_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f zx_mem.f --top-module zx_mem_tb \
	-Mdir obj_dir -o zx_mem_sim || { echo "Build failed"; exit 1; }

./obj_dir/zx_mem_sim 2>&1 | tee sim.log

grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== dv/zx_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_mem_tb;

	localparam int AW = 18;
	localparam int LIMIT = 20000;
	localparam int BANK = 16384;

	logic clk_sys;
	logic reset;
	logic [15:0] addr;
	logic [7:0] cpu_dout;
	logic mreq;
	logic iorq;
	logic rd;
	logic wr;
	logic ioctl_download;
	logic ioctl_wr;
	logic [15:0] ioctl_addr;
	logic [7:0] ioctl_index;
	logic [7:0] ioctl_dout;
	logic tape_req;
	logic [15:0] tape_addr;
	logic mode_48;
	logic [4:0] key_data;
	logic ear_in;
	logic [5:0] joy;
	wire [7:0] cpu_din;
	wire cpu_hold;
	wire [7:0] tape_data;
	wire [2:0] border;
	wire ear_out;
	wire mic_out;

	// Reference model state
	logic [7:0] model_mem [1 << AW];
	bit model_ok [1 << AW];
	logic [7:0] model_pg;
	logic [2:0] model_border;
	logic model_ear;
	logic model_mic;

	logic [31:0] lfsr = 32'h1231_9518;
	int cycles = 0;

	zx_mem_top #(
		.PHYS_AW(AW)
	) dut_i (
		.clk_sys(clk_sys), .reset(reset),
		.addr(addr), .cpu_dout(cpu_dout), .mreq(mreq), .iorq(iorq), .rd(rd), .wr(wr),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_index(ioctl_index), .ioctl_dout(ioctl_dout),
		.tape_req(tape_req), .tape_addr(tape_addr),
		.mode_48(mode_48), .key_data(key_data), .ear_in(ear_in), .joy(joy),
		.cpu_din(cpu_din), .cpu_hold(cpu_hold), .tape_data(tape_data),
		.border(border), .ear_out(ear_out), .mic_out(mic_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout, the run went past %0d cycles", LIMIT);
			$display("Checks failed");
			$fatal(1, "cycle limit reached");
		end
	end

	// ====================
	// Helpers
	// ====================

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic lsb;
		r = 32'd0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb) lfsr = lfsr ^ 32'hA300_0000;
			r[i] = lsb;
		end
		return r;
	endfunction

	// Z80 address to physical byte index
	function automatic int phys_of(input logic [15:0] a);
		int bank;
		case (a[15:14])
			2'd0: bank = 8 + int'(model_pg[4] | mode_48);
			2'd1: bank = 5;
			2'd2: bank = 2;
			default: bank = int'(model_pg[2:0]);
		endcase
		return bank * BANK + int'(a[13:0]);
	endfunction

	task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected) begin
			$display("error %s expected %h actual %h", name, expected, actual);
			$display("Checks failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic do_reset();
		reset = 1'b1;
		repeat (10) @(negedge clk_sys);
		reset = 1'b0;
		model_pg = 8'h00;
		model_border = 3'd0;
		model_ear = 1'b0;
		model_mic = 1'b0;
	endtask

	task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
		addr = a;
		cpu_dout = d;
		mreq = 1'b1;
		wr = 1'b1;
		if (a[15:14] != 2'd0) begin
			model_mem[phys_of(a)] = d;
			model_ok[phys_of(a)] = 1'b1;
		end
		@(negedge clk_sys);
		mreq = 1'b0;
		wr = 1'b0;
	endtask

	task automatic mem_read(input logic [15:0] a);
		int p;
		p = phys_of(a);
		addr = a;
		mreq = 1'b1;
		rd = 1'b1;
		@(negedge clk_sys);
		if (model_ok[p]) check("mem read", model_mem[p], cpu_din);
		mreq = 1'b0;
		rd = 1'b0;
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		addr = a;
		cpu_dout = d;
		iorq = 1'b1;
		wr = 1'b1;
		if (!a[0]) begin
			model_border = d[2:0];
			model_mic = d[3];
			model_ear = d[4];
		end
		if (!a[15] && !a[1] && !(model_pg[5] | mode_48)) model_pg = d;
		@(negedge clk_sys);
		iorq = 1'b0;
		wr = 1'b0;
		check("border", 8'(model_border), 8'(border));
		check("ear out", 8'(model_ear), 8'(ear_out));
		check("mic out", 8'(model_mic), 8'(mic_out));
		// Idle cycle so the next write is a fresh edge
		@(negedge clk_sys);
	endtask

	task automatic io_read(input logic [15:0] a);
		logic [7:0] exp_v;
		if (a[7:0] == 8'h1F) exp_v = {2'b00, joy};
		else if (!a[0]) exp_v = {1'b1, ear_in, 1'b1, key_data};
		else exp_v = 8'hFF;
		addr = a;
		iorq = 1'b1;
		rd = 1'b1;
		@(negedge clk_sys);
		check("io read", exp_v, cpu_din);
		iorq = 1'b0;
		rd = 1'b0;
	endtask

	task automatic tape_read(input logic [15:0] a);
		tape_req = 1'b1;
		tape_addr = a;
		@(negedge clk_sys);
		check("tape read", model_mem[12 * BANK + int'(a)], tape_data);
	endtask

	// ====================
	// Tests
	// ====================

	initial begin
		logic [15:0] a;
		logic [2:0] op;
		reset = 1'b1;
		addr = 16'd0;
		cpu_dout = 8'd0;
		{mreq, iorq, rd, wr} = 4'd0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = 16'd0;
		ioctl_index = 8'd0;
		ioctl_dout = 8'd0;
		tape_req = 1'b0;
		tape_addr = 16'd0;
		mode_48 = 1'b0;
		key_data = 5'd0;
		ear_in = 1'b0;
		joy = 6'd0;
		@(negedge clk_sys);
		do_reset();

		// Loader fills the start of both ROM pages, then the tape area
		ioctl_download = 1'b1;
		for (int i = 0; i < 1024; i++) begin
			ioctl_index = (i < 512) ? 8'd0 : 8'd1;
			ioctl_addr = (i < 256) ? 16'(i) : (i < 512) ? 16'(16'h4000 + i - 256) : 16'(i - 512);
			ioctl_dout = 8'(rand_bits(8));
			ioctl_wr = 1'b1;
			if (i < 512) begin
				model_mem[8 * BANK + int'(ioctl_addr)] = ioctl_dout;
				model_ok[8 * BANK + int'(ioctl_addr)] = 1'b1;
			end else begin
				model_mem[12 * BANK + int'(ioctl_addr)] = ioctl_dout;
				model_ok[12 * BANK + int'(ioctl_addr)] = 1'b1;
			end
			@(negedge clk_sys);
			check("cpu hold", 8'd1, 8'(cpu_hold));
		end
		ioctl_wr = 1'b0;
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		check("cpu hold", 8'd0, 8'(cpu_hold));
		for (int i = 0; i < 256; i++) tape_read(16'(rand_bits(9)));
		tape_req = 1'b0;

		// Page markers in every RAM bank
		for (int p = 0; p < 8; p++) begin
			io_write(16'h7FFD, 8'(p));
			mem_write(16'hFFF0, 8'(8'hA0 + p));
		end

		// Random Z80 traffic under paging
		for (int i = 0; i < 800; i++) begin
			op = 3'(rand_bits(3));
			a = {2'(rand_bits(2)), 9'd0, 5'(rand_bits(5))};
			if (op <= 3'd2) mem_write(a, 8'(rand_bits(8)));
			else if (op <= 3'd5) mem_read(a);
			else if (op == 3'd6) io_write(16'h7FFD, 8'(rand_bits(8)) & 8'hDF);
			else mem_read({8'h00, 8'(rand_bits(8))});
		end

		// Lock bit, then 48K mode
		io_write(16'h7FFD, 8'h23);
		mem_read(16'hFFF0);
		io_write(16'h7FFD, 8'h16);
		mem_read(16'hFFF0);
		for (int i = 0; i < 4; i++) mem_read(16'(i));
		mode_48 = 1'b1;
		for (int i = 0; i < 4; i++) mem_read(16'(i));
		mode_48 = 1'b0;

		// ULA port and I/O read decode
		for (int i = 0; i < 40; i++) io_write(16'h00FE, 8'(rand_bits(8)));
		for (int i = 0; i < 120; i++) begin
			key_data = 5'(rand_bits(5));
			ear_in = rand_bits(1) != 32'd0;
			joy = 6'(rand_bits(6));
			op = 3'(rand_bits(2));
			if (op == 3'd0) io_read(16'h00FE);
			else if (op == 3'd1) io_read(16'h001F);
			else io_read(16'(rand_bits(16)));
		end

		// Z80 write loses to the tape
		mem_write(16'h7FE0, 8'h11);
		addr = 16'h7FE0;
		cpu_dout = 8'hEE;
		mreq = 1'b1;
		wr = 1'b1;
		tape_read(16'd5);
		tape_req = 1'b0;
		mreq = 1'b0;
		wr = 1'b0;
		mem_read(16'h7FE0);

		// Mid-run reset clears paging and ULA outputs
		io_write(16'h00FE, 8'h1F);
		do_reset();
		@(negedge clk_sys);
		check("border after reset", 8'd0, 8'(border));
		check("ear after reset", 8'd0, 8'(ear_out));
		check("mic after reset", 8'd0, 8'(mic_out));
		mem_read(16'hFFF0);
		mem_read(16'h0001);
		mode_48 = 1'b1;
		io_write(16'h7FFD, 8'h05);
		mem_read(16'hFFF0);
		mem_read(16'h0001);
		mode_48 = 1'b0;
		io_write(16'h7FFD, 8'h05);
		mem_read(16'hFFF0);

		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/zx_mem_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_mem_chk (
	input wire clk_sys,
	input wire reset,
	input wire [15:0] addr,
	input wire mreq,
	input wire wr,
	input wire tape_req,
	input wire ioctl_download,
	input wire ram_we,
	input wire cpu_hold
);

	// ====================
	// Arbiter properties
	// ====================

	// Z80 owns the bus and writes the ROM slot
	a_rom_wr_blocked: assert property (@(posedge clk_sys) disable iff (reset)
		(mreq && wr && !ioctl_download && !tape_req && addr[15:14] == 2'd0) |-> !ram_we)
		else $error("RAM write enabled for a Z80 write to the ROM slot");

	// BUSRQ mirrors the download level
	a_hold: assert property (@(posedge clk_sys) cpu_hold == ioctl_download)
		else $error("cpu_hold differs from ioctl_download");

endmodule

bind mem_arbiter zx_mem_chk zx_mem_chk_i (
	.clk_sys(clk_sys),
	.reset(reset),
	.addr(addr),
	.mreq(mreq),
	.wr(wr),
	.tape_req(tape_req),
	.ioctl_download(ioctl_download),
	.ram_we(ram_we),
	.cpu_hold(cpu_hold)
);

`default_nettype wire

// ==== hw/zx_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module zx_mem_top #(
	parameter int PHYS_AW = 18
) (
	input wire clk_sys,
	input wire reset,

	// Z80 bus, active-high strobes
	input wire [15:0] addr,
	input wire [7:0] cpu_dout,
	input wire mreq,
	input wire iorq,
	input wire rd,
	input wire wr,

	// Loader
	input wire ioctl_download,
	input wire ioctl_wr,
	input wire [15:0] ioctl_addr,
	input wire [7:0] ioctl_index,
	input wire [7:0] ioctl_dout,

	// Tape buffer reader
	input wire tape_req,
	input wire [15:0] tape_addr,

	input wire mode_48,
	input wire [4:0] key_data,
	input wire ear_in,
	input wire [5:0] joy,

	output logic [7:0] cpu_din,
	output logic cpu_hold,
	output logic [7:0] tape_data,
	output logic [2:0] border,
	output logic ear_out,
	output logic mic_out
);
	import zx_pkg::*;

	logic rom_page;
	logic [$clog2(RAM_BANKS)-1:0] ram_page;
	logic [7:0] io_dout;
	logic [PHYS_AW-1:0] ram_addr;
	logic [7:0] ram_din;
	logic ram_we;
	logic [7:0] ram_dout;

	// ====================
	// Z80 side registers
	// ====================

	page_regs page_regs_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.addr(addr),
		.cpu_dout(cpu_dout),
		.iorq(iorq),
		.wr(wr),
		.mode_48(mode_48),
		.rom_page(rom_page),
		.ram_page(ram_page)
	);

	io_ports io_ports_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.addr(addr),
		.cpu_dout(cpu_dout),
		.iorq(iorq),
		.rd(rd),
		.wr(wr),
		.key_data(key_data),
		.ear_in(ear_in),
		.joy(joy),
		.io_dout(io_dout),
		.border(border),
		.ear_out(ear_out),
		.mic_out(mic_out)
	);

	// ====================
	// Shared RAM
	// ====================

	mem_arbiter #(
		.PHYS_AW(PHYS_AW)
	) mem_arbiter_i (
		.clk_sys(clk_sys),
		.reset(reset),
		.addr(addr),
		.cpu_dout(cpu_dout),
		.mreq(mreq),
		.iorq(iorq),
		.rd(rd),
		.wr(wr),
		.ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_index(ioctl_index),
		.ioctl_dout(ioctl_dout),
		.tape_req(tape_req),
		.tape_addr(tape_addr),
		.rom_page(rom_page),
		.ram_page(ram_page),
		.io_dout(io_dout),
		.ram_dout(ram_dout),
		.ram_addr(ram_addr),
		.ram_din(ram_din),
		.ram_we(ram_we),
		.cpu_din(cpu_din),
		.tape_data(tape_data),
		.cpu_hold(cpu_hold)
	);

	bank_ram #(
		.PHYS_AW(PHYS_AW)
	) bank_ram_i (
		.clk_sys(clk_sys),
		.ram_addr(ram_addr),
		.ram_din(ram_din),
		.ram_we(ram_we),
		.ram_dout(ram_dout)
	);

endmodule

`default_nettype wire

// ==== hw/bank_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_ram #(
	parameter int PHYS_AW = 18
) (
	input wire clk_sys,

	// Single shared port
	input wire [PHYS_AW-1:0] ram_addr,
	input wire [7:0] ram_din,
	input wire ram_we,

	output logic [7:0] ram_dout
);

	// ====================
	// Storage
	// ====================

	localparam int DEPTH = 1 << PHYS_AW;

	// ROM pages and tape buffer live here too
	logic [7:0] mem [DEPTH];

	// ====================
	// Write port
	// ====================

	// Write lands at the clock edge
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_din;
		end
	end

	// ====================
	// Read port
	// ====================

	// Registered read, one cycle of latency
	// A write cycle returns the old contents
	always_ff @(posedge clk_sys) begin
		ram_dout <= mem[ram_addr];
	end

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
	parameter int PHYS_AW = 18
) (
	input wire clk_sys,
	input wire reset,

	// Z80 bus
	input wire [15:0] addr,
	input wire [7:0] cpu_dout,
	input wire mreq,
	input wire iorq,
	input wire rd,
	input wire wr,

	// Loader
	input wire ioctl_download,
	input wire ioctl_wr,
	input wire [15:0] ioctl_addr,
	input wire [7:0] ioctl_index,
	input wire [7:0] ioctl_dout,

	// Tape buffer reader
	input wire tape_req,
	input wire [15:0] tape_addr,

	input wire rom_page,
	input wire [$clog2(zx_pkg::RAM_BANKS)-1:0] ram_page,
	input wire [7:0] io_dout,
	input wire [7:0] ram_dout,

	output logic [PHYS_AW-1:0] ram_addr,
	output logic [7:0] ram_din,
	output logic ram_we,
	output logic [7:0] cpu_din,
	output logic [7:0] tape_data,
	output logic cpu_hold
);
	import zx_pkg::*;

	localparam int BANK_W = PHYS_AW - BANK_AW;
	localparam logic [PHYS_AW-1:0] ROM_BASE = PHYS_AW'(ROM_BANK0) << BANK_AW;
	localparam logic [PHYS_AW-1:0] TAPE_BASE = PHYS_AW'(TAPE_BANK) << BANK_AW;

	bus_src_e src;
	bus_src_e src_q;
	logic [BANK_W-1:0] cpu_bank;
	logic cpu_wr_ok;
	logic mem_rd_q;
	logic [7:0] cpu_din_q;
	logic [7:0] tape_data_q;

	// ====================
	// Grant and mapping
	// ====================

	// Loader over tape over Z80
	always_comb begin
		if (ioctl_download) src = SRC_LOADER;
		else if (tape_req) src = SRC_TAPE;
		else if (mreq) src = SRC_CPU;
		else src = SRC_NONE;
	end

	// 16 KB slot to physical bank
	always_comb begin
		case (addr[15:14])
			2'd0: cpu_bank = BANK_W'(ROM_BANK0) + BANK_W'(rom_page);
			2'd1: cpu_bank = BANK_W'(5);
			2'd2: cpu_bank = BANK_W'(2);
			default: cpu_bank = BANK_W'(ram_page);
		endcase
	end

	// ROM slot is read only for the Z80
	assign cpu_wr_ok = mreq & wr & (addr[15:14] != 2'd0);

	always_comb begin
		ram_addr = {cpu_bank, addr[BANK_AW-1:0]};
		ram_din = cpu_dout;
		ram_we = 1'b0;
		case (src)
			SRC_LOADER: begin
				ram_addr = ((ioctl_index != 8'd0) ? TAPE_BASE : ROM_BASE) + PHYS_AW'(ioctl_addr);
				ram_din = ioctl_dout;
				ram_we = ioctl_wr;
			end
			SRC_TAPE: ram_addr = TAPE_BASE + PHYS_AW'(tape_addr);
			SRC_CPU: ram_we = cpu_wr_ok;
			SRC_NONE: ram_we = 1'b0;
			default: ram_we = 1'b0;
		endcase
	end

	// BUSRQ for the whole download
	assign cpu_hold = ioctl_download;

	// ====================
	// Read return
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			src_q <= SRC_NONE;
			mem_rd_q <= 1'b0;
		end else begin
			src_q <= src;
			mem_rd_q <= mreq & rd & (src != SRC_LOADER);
		end
	end

	// Hold registers keep the last returned byte
	always_ff @(posedge clk_sys) begin
		cpu_din_q <= (iorq & rd) ? io_dout : cpu_din;
		tape_data_q <= tape_data;
	end

	// A Z80 read that lost to the tape sees the tape byte
	assign cpu_din = mem_rd_q ? ram_dout : cpu_din_q;
	assign tape_data = (src_q == SRC_TAPE) ? ram_dout : tape_data_q;

endmodule

`default_nettype wire

// ==== hw/io_ports.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_ports (
	input wire clk_sys,
	input wire reset,

	// Z80 bus
	input wire [15:0] addr,
	input wire [7:0] cpu_dout,
	input wire iorq,
	input wire rd,
	input wire wr,

	// Inputs read back through the ports
	input wire [4:0] key_data,
	input wire ear_in,
	input wire [5:0] joy,

	output logic [7:0] io_dout,
	output logic [2:0] border,
	output logic ear_out,
	output logic mic_out
);
	import zx_pkg::*;

	logic ula_we;
	logic ula_we_q;

	// ULA answers on any even port
	assign ula_we = iorq & wr & ~addr[0];

	// ====================
	// Port FE write
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula_we_q <= 1'b0;
			border <= 3'd0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else begin
			ula_we_q <= ula_we;
			// Act once per write cycle
			if (ula_we & ~ula_we_q) begin
				border <= cpu_dout[2:0];
				ear_out <= cpu_dout[4];
				mic_out <= cpu_dout[3];
			end
		end
	end

	// ====================
	// Read decode
	// ====================

	// Kempston checked first, 1F is odd anyway
	always_comb begin
		io_dout = IO_IDLE;
		if (iorq & rd) begin
			if (addr[7:0] == PORT_KEMPSTON) begin
				io_dout = {2'b00, joy};
			end else if (~addr[0]) begin
				io_dout = {1'b1, ear_in, 1'b1, key_data};
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/page_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module page_regs (
	input wire clk_sys,
	input wire reset,

	// Z80 bus
	input wire [15:0] addr,
	input wire [7:0] cpu_dout,
	input wire iorq,
	input wire wr,

	// Plain 48K machine, paging frozen
	input wire mode_48,

	output logic rom_page,
	output logic [$clog2(zx_pkg::RAM_BANKS)-1:0] ram_page
);

	// ====================
	// Decode
	// ====================

	logic io_wr;
	logic io_wr_q;
	logic page_sel;
	logic page_lock;
	logic page_load;

	// Full 7FFD register, bits 3, 6 and 7 are kept but not used here
	logic [7:0] page_reg;

	assign io_wr = iorq & wr;

	// Partial decode, A15 and A1 low
	assign page_sel = ~addr[15] & ~addr[1];

	// Bit 5 locks paging until the next reset
	assign page_lock = page_reg[5] | mode_48;

	// Rising edge of the decoded write
	assign page_load = io_wr & ~io_wr_q & page_sel & ~page_lock;

	// ====================
	// Register
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			page_reg <= 8'h00;
		end else begin
			io_wr_q <= io_wr;
			if (page_load) begin
				page_reg <= cpu_dout;
			end
		end
	end

	// ====================
	// Outputs
	// ====================

	// RAM page at C000
	assign ram_page = page_reg[2:0];

	// 48K BASIC ROM forced in 48K mode
	assign rom_page = page_reg[4] | mode_48;

endmodule

`default_nettype wire

// ==== hw/zx_pkg.sv ====
`default_nettype none

package zx_pkg;

	// ====================
	// Memory map
	// ====================

	// One 16 KB bank
	localparam int BANK_AW = 14;

	// RAM pages 0..7 sit at physical banks 0..7
	localparam int RAM_BANKS = 8;

	// Two ROM pages at banks 8 and 9
	localparam int ROM_BANK0 = 8;

	// Tape buffer base, room above it depends on the physical width
	localparam int TAPE_BANK = 12;

	// ====================
	// I/O ports
	// ====================

	// Kempston joystick, low address byte
	localparam logic [7:0] PORT_KEMPSTON = 8'h1F;

	// Floating bus value for undecoded reads
	localparam logic [7:0] IO_IDLE = 8'hFF;

	// Winner of the shared RAM in a given cycle
	typedef enum logic [1:0] {
		SRC_LOADER = 2'd0,
		SRC_TAPE   = 2'd1,
		SRC_CPU    = 2'd2,
		SRC_NONE   = 2'd3
	} bus_src_e;

endpackage

`default_nettype wire
